//--- Makefile
# Verilator simulation of the histogram peak finder

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail on a failing log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert --top-module sifhTb -f sifh.f -o VsifhTb
	./obj_dir/VsifhTb > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "\*\* FAIL \*\*" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/binBus.sv
// Bin update channel
// Carries each counted sample's new bin value from the histogram builder
// to the peak tracker
interface binBus;

    logic           upd;     // One cycle per counted sample
    sifhPkg::pixT   pix;     // Pixel of the update
    sifhPkg::binT   bin;     // Bin that was bumped
    sifhPkg::countT count;   // Its value after the bump

    // Builder side drives everything
    modport builder (
        output upd, pix, bin, count
    );

    // Tracker only watches
    modport tracker (
        input upd, pix, bin, count
    );

endinterface

//--- hdl/histBuilder.sv
// Histogram builder
// Bin memory with per-bin valid bits, read-increment-write per sample,
// sample/pixel/acquisition counters and coarse/fine pass sequencing
module histBuilder (
    input  logic          clk,
    input  logic          combin_res,
    input  logic          wrEn,
    input  logic          keep,
    input  sifhPkg::binT  bin,
    output sifhPkg::pixT  curPix,
    output sifhPkg::passT pass,
    output logic          busy,
    output logic          passEnd,
    binBus.builder        bus
);

    // ************************************************************************
    // Storage and counters
    // ************************************************************************
    sifhPkg::countT mem [sifhPkg::PIXEL_NUM * sifhPkg::BIN_NUM];   // Bin counts
    logic [sifhPkg::PIXEL_NUM*sifhPkg::BIN_NUM-1:0] validBits;       // Bin is live
    logic [$bits(sifhPkg::pixT)+sifhPkg::NB-1:0] addr;              // {pixel, bin}
    logic [$clog2(sifhPkg::DATA_NUM)-1:0] sampleCnt;               // Within a pixel
    logic [$clog2(sifhPkg::ACQ_NUM)-1:0]  acqCnt;                  // Within a pass

    logic           accept;       // Strobe taken this cycle
    logic           lastSample;   // Closes the pass
    sifhPkg::countT stored;
    sifhPkg::countT newCount;

    assign accept = wrEn && !busy;   // Busy is the only back-pressure
    assign addr   = {curPix, bin};
    assign stored = mem[addr];

    assign lastSample = accept
                     && (sampleCnt == sifhPkg::DATA_NUM - 1)
                     && (curPix == sifhPkg::PIXEL_NUM - 1)
                     && (acqCnt == sifhPkg::ACQ_NUM - 1);

    // Stale bins restart at one, live bins saturate
    always_comb begin
        if (!validBits[addr])
            newCount = sifhPkg::countT'(1);
        else if (stored == '1)
            newCount = stored;
        else
            newCount = stored + 1'b1;
    end

    // ************************************************************************
    // Control: counters, valid bits, pass FSM and drain
    // ************************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            curPix    <= '0;
            acqCnt    <= '0;
            pass      <= sifhPkg::COARSE;
            busy      <= 1'b0;
            passEnd   <= 1'b0;
            validBits <= '0;
            bus.upd   <= 1'b0;
        end else begin
            bus.upd <= accept && keep;   // Dropped samples raise no event
            passEnd <= lastSample;

            if (accept) begin
                if (keep)
                    validBits[addr] <= 1'b1;
                if (sampleCnt == sifhPkg::DATA_NUM - 1) begin
                    sampleCnt <= '0;
                    if (curPix == sifhPkg::PIXEL_NUM - 1) begin
                        curPix <= '0;
                        if (acqCnt == sifhPkg::ACQ_NUM - 1)
                            acqCnt <= '0;     // Pass complete
                        else
                            acqCnt <= acqCnt + 1'b1;
                    end else begin
                        curPix <= curPix + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end

            // Two-cycle drain after the last sample
            if (lastSample) begin
                busy <= 1'b1;
            end else if (passEnd) begin
                validBits <= '0;              // Drain 1, wipe histogram
            end else if (busy) begin
                busy <= 1'b0;                 // Drain 2, next pass
                pass <= (pass == sifhPkg::COARSE) ? sifhPkg::FINE : sifhPkg::COARSE;
            end
        end
    end

    // Bin memory write
    always_ff @(posedge clk) begin
        if (accept && keep)
            mem[addr] <= newCount;
    end

    // Update event payload, qualified by upd
    always_ff @(posedge clk) begin
        if (accept && keep) begin
            bus.pix   <= curPix;
            bus.bin   <= bin;
            bus.count <= newCount;
        end
    end

endmodule

//--- hdl/peakTracker.sv
// Peak tracker
// Running maximum count and its bin per pixel, presented one cycle after
// the pass ends
module peakTracker (
    input  logic                                  clk,
    input  logic                                  combin_res,
    binBus.tracker                                bus,
    input  logic                                  passEnd,
    output sifhPkg::binT [sifhPkg::PIXEL_NUM-1:0] peakBin,
    output logic                                  peakValid
);

    sifhPkg::countT maxCnt [sifhPkg::PIXEL_NUM];   // Best count so far
    sifhPkg::binT   maxBin [sifhPkg::PIXEL_NUM];   // Bin that reached it first
    logic [sifhPkg::PIXEL_NUM-1:0]         hit;     // Update beats the max
    sifhPkg::binT [sifhPkg::PIXEL_NUM-1:0] nextBin; // Peak including this update

    // Strictly greater so ties keep the earlier bin
    always_comb begin
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            hit[p]     = bus.upd && (bus.pix == p) && (bus.count > maxCnt[p]);
            nextBin[p] = hit[p] ? bus.bin : maxBin[p];
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            peakBin   <= '0;
            peakValid <= 1'b0;
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                maxCnt[p] <= '0;
                maxBin[p] <= '0;
            end
        end else begin
            peakValid <= passEnd;
            if (passEnd) begin
                peakBin <= nextBin;   // Last update lands with passEnd
                for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                    maxCnt[p] <= '0;  // Fresh start for the next pass
                    maxBin[p] <= '0;
                end
            end else begin
                for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
                    if (hit[p]) begin
                        maxCnt[p] <= bus.count;
                        maxBin[p] <= bus.bin;
                    end
                end
            end
        end
    end

endmodule

//--- hdl/sampleFilter.sv
// Sample filter
// Maps a timestamp onto its histogram bin: top bits in the coarse pass,
// offset inside the pixel's window in the fine pass
module sampleFilter (
    input  sifhPkg::sampleT                          data,
    input  sifhPkg::passT                            pass,
    input  sifhPkg::pixT                             curPix,
    input  sifhPkg::sampleT [sifhPkg::PIXEL_NUM-1:0] winLow,
    output logic                                     keep,
    output sifhPkg::binT                             bin
);

    sifhPkg::sampleT base;     // Window start of the current pixel
    sifhPkg::sampleT offset;   // Distance from the window start

    assign base   = winLow[curPix];
    assign offset = data - base;   // Wraps when below base, caught by keep

    always_comb begin
        if (pass == sifhPkg::COARSE) begin
            bin  = data[sifhPkg::NP-1 -: sifhPkg::NB];   // Coarse code
            keep = 1'b1;
        end else begin
            bin  = offset[sifhPkg::NB-1:0];
            // Inside [base, base + WIN)
            keep = (data >= base) && (offset < sifhPkg::WIN);
        end
    end

endmodule

//--- hdl/sifhPkg.sv
// Histogram peak finder shared definitions
// Frame dimensions, code widths, window constants and the pass state
package sifhPkg;

    // ************************************************************************
    // Widths and frame dimensions
    // ************************************************************************
    localparam int NP        = 12;          // Timestamp width
    localparam int NB        = 4;           // Bin index width
    localparam int PIXEL_NUM = 4;           // Pixels per acquisition
    localparam int DATA_NUM  = 4;           // Samples per pixel
    localparam int ACQ_NUM   = 2;           // Acquisitions per pass
    localparam int BIN_NUM   = 2 ** NB;     // Bins per pixel histogram
    localparam int CNT_W     = 8;           // Bin counter width

    // ************************************************************************
    // Fine window
    // ************************************************************************
    localparam int HALF_WIN = 2 ** (NB - 1);  // Half window in fine codes
    localparam int WIN      = 2 ** NB;        // Full window width
    localparam int WIN_TOP  = 2 ** NP - WIN;  // Highest legal window base

    // Types
    typedef logic [NP-1:0]    sampleT;   // Raw timestamp
    typedef logic [NB-1:0]    binT;      // Histogram bin
    typedef logic [1:0]       pixT;      // Pixel index
    typedef logic [CNT_W-1:0] countT;    // Bin occupancy

    // Which histogram is being built
    typedef enum logic {
        COARSE = 1'b0,   // Top NB bits of the code
        FINE   = 1'b1    // Offset inside the window
    } passT;

endpackage

//--- hdl/sifhTop.sv
// Two-pass histogram peak finder
// Filter, histogram builder, peak tracker and window calculator in a loop,
// one result per pixel three cycles after a frame's last sample
module sifhTop (
    input  logic                                     clk,
    input  logic                                     combin_res,
    input  logic                                     wrEn,
    input  sifhPkg::sampleT                          data,
    output logic                                     busy,
    output sifhPkg::passT                            pass,
    output sifhPkg::sampleT [sifhPkg::PIXEL_NUM-1:0] result,
    output logic                                     resultValid
);

    logic                                     keep;       // Sample lands in a bin
    sifhPkg::binT                             bin;
    sifhPkg::pixT                             curPix;
    logic                                     passEnd;
    sifhPkg::binT [sifhPkg::PIXEL_NUM-1:0]    peakBin;
    logic                                     peakValid;
    sifhPkg::sampleT [sifhPkg::PIXEL_NUM-1:0] winLow;     // Feedback to the filter

    binBus updBus ();

    sampleFilter uFilter (
        .data   (data),
        .pass   (pass),
        .curPix (curPix),
        .winLow (winLow),
        .keep   (keep),
        .bin    (bin)
    );

    histBuilder uBuilder (
        .clk        (clk),
        .combin_res (combin_res),
        .wrEn       (wrEn),
        .keep       (keep),
        .bin        (bin),
        .curPix     (curPix),
        .pass       (pass),
        .busy       (busy),
        .passEnd    (passEnd),
        .bus        (updBus.builder)
    );

    peakTracker uTracker (
        .clk        (clk),
        .combin_res (combin_res),
        .bus        (updBus.tracker),
        .passEnd    (passEnd),
        .peakBin    (peakBin),
        .peakValid  (peakValid)
    );

    windowCalc uWindow (
        .clk         (clk),
        .combin_res  (combin_res),
        .pass        (pass),
        .peakBin     (peakBin),
        .peakValid   (peakValid),
        .winLow      (winLow),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

//--- hdl/windowCalc.sv
// Window calculator
// Coarse peaks become clamped fine window bases, fine peaks become results
module windowCalc (
    input  logic                                     clk,
    input  logic                                     combin_res,
    input  sifhPkg::passT                            pass,
    input  sifhPkg::binT [sifhPkg::PIXEL_NUM-1:0]    peakBin,
    input  logic                                     peakValid,
    output sifhPkg::sampleT [sifhPkg::PIXEL_NUM-1:0] winLow,
    output sifhPkg::sampleT [sifhPkg::PIXEL_NUM-1:0] result,
    output logic                                     resultValid
);

    sifhPkg::sampleT [sifhPkg::PIXEL_NUM-1:0] centre;   // Coarse peak in fine codes
    sifhPkg::sampleT [sifhPkg::PIXEL_NUM-1:0] base;     // Clamped window start

    always_comb begin
        for (int p = 0; p < sifhPkg::PIXEL_NUM; p++) begin
            centre[p] = {peakBin[p], {(sifhPkg::NP - sifhPkg::NB){1'b0}}};
            if (centre[p] <= sifhPkg::HALF_WIN)
                base[p] = '0;                                   // Pinned low
            else if (centre[p] >= sifhPkg::WIN_TOP)
                base[p] = sifhPkg::sampleT'(sifhPkg::WIN_TOP);  // Pinned high
            else
                base[p] = centre[p] - sifhPkg::sampleT'(sifhPkg::HALF_WIN);
        end
    end

    // ************************************************************************
    // Window hold and result strobe
    // ************************************************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLow      <= '0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= peakValid && (pass == sifhPkg::FINE);
            if (peakValid && (pass == sifhPkg::COARSE))
                winLow <= base;   // Held through the fine pass
        end
    end

    // Result = window base + fine peak
    always_ff @(posedge clk) begin
        if (peakValid && (pass == sifhPkg::FINE)) begin
            for (int p = 0; p < sifhPkg::PIXEL_NUM; p++)
                result[p] <= winLow[p] + {{(sifhPkg::NP - sifhPkg::NB){1'b0}}, peakBin[p]};
        end
    end

endmodule

//--- sifh.f
hdl/sifhPkg.sv
hdl/binBus.sv
hdl/sampleFilter.sv
hdl/histBuilder.sv
hdl/peakTracker.sv
hdl/windowCalc.sv
hdl/sifhTop.sv
tests/clockGen.sv
tests/sifhTop_properties.sv
tests/sifhTb.sv

//--- tests/clockGen.sv
// Testbench clock and reset
// Free-running clock, reset held low for the first two rising edges
module clockGen #(
    parameter int HALF_PERIOD = 5
) (
    output logic clk,
    output logic combin_res
);

    initial begin
        clk        = 1'b0;
        combin_res = 1'b0;              // Asserted from time zero
        repeat (2) @(posedge clk);
        combin_res <= 1'b1;
    end

    always #HALF_PERIOD clk = ~clk;     // Period of 10

endmodule

//--- tests/sifhTb.sv
// Peak finder testbench
// Directed frames against a stream-order reference of the two-pass rules
module sifhTb;

    localparam int PASS_SAMPLES = sifhPkg::ACQ_NUM * sifhPkg::PIXEL_NUM * sifhPkg::DATA_NUM;
    localparam int FRAME_COUNT  = 9;                            // Frames over all tests
    localparam int TIMEOUT      = FRAME_COUNT * 2 * (PASS_SAMPLES + 3) + 200;

    logic                                     clk;
    logic                                     combin_res;
    logic                                     wrEn;
    sifhPkg::sampleT                          data;
    logic                                     busy;
    sifhPkg::passT                            pass;
    sifhPkg::sampleT [sifhPkg::PIXEL_NUM-1:0] result;
    logic                                     resultValid;

    sifhPkg::sampleT stim [2 * PASS_SAMPLES];   // Coarse half then fine half
    int              expRes [sifhPkg::PIXEL_NUM];
    int              errCount   = 0;
    int              checkCount = 0;
    int              cycles     = 0;
    logic [31:0]     lfsrState  = 32'hc667_5bf7;

    clockGen uClk (
        .clk        (clk),
        .combin_res (combin_res)
    );

    sifhTop u_dut (
        .clk         (clk),
        .combin_res  (combin_res),
        .wrEn        (wrEn),
        .data        (data),
        .busy        (busy),
        .pass        (pass),
        .result      (result),
        .resultValid (resultValid)
    );

    // ************************************************************************
    // Stimulus helpers
    // ************************************************************************
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic lfsrBit();
        logic fb;
        fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic int randBits(int n);
        int r;
        r = 0;
        for (int k = 0; k < n; k++)
            r = (r << 1) | int'(lfsrBit());
        return r;
    endfunction

    // Samples clustered at a centre per pixel, optionally mixed with noise
    task automatic buildPeaked(input int centre [sifhPkg::PIXEL_NUM], input bit noisy);
        int i;
        int p;
        for (int f = 0; f < 2 * PASS_SAMPLES; f++) begin
            i = f % PASS_SAMPLES;
            p = (i / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM;
            if (noisy && lfsrBit())
                stim[f] = sifhPkg::sampleT'(randBits(sifhPkg::NP));   // Anywhere
            else if (noisy)
                stim[f] = sifhPkg::sampleT'(centre[p] + randBits(2));
            else
                stim[f] = sifhPkg::sampleT'(centre[p] + ((i % 4 == 3) ? 1 : 0));
        end
    endtask

    // Reference for one frame, fills expRes
    task automatic modelFrame();
        int cnt  [sifhPkg::PIXEL_NUM][sifhPkg::BIN_NUM];
        int maxC [sifhPkg::PIXEL_NUM];
        int maxB [sifhPkg::PIXEL_NUM];
        int wl   [sifhPkg::PIXEL_NUM];
        int d;
        int p;
        int b;
        int ch;
        bit kept;
        foreach (wl[q]) wl[q] = 0;
        for (int ps = 0; ps < 2; ps++) begin
            foreach (cnt[q, k]) cnt[q][k] = 0;       // Histogram starts empty
            foreach (maxC[q]) begin
                maxC[q] = 0;
                maxB[q] = 0;
            end
            for (int i = 0; i < PASS_SAMPLES; i++) begin
                d = int'(stim[ps * PASS_SAMPLES + i]);
                p = (i / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM;
                if (ps == 0) begin
                    kept = 1'b1;
                    b    = d >> (sifhPkg::NP - sifhPkg::NB);
                end else begin
                    kept = (d >= wl[p]) && (d < wl[p] + sifhPkg::WIN);
                    b    = d - wl[p];
                end
                if (kept) begin
                    if (cnt[p][b] < 255)
                        cnt[p][b]++;
                    if (cnt[p][b] > maxC[p]) begin   // First to the top keeps it
                        maxC[p] = cnt[p][b];
                        maxB[p] = b;
                    end
                end
            end
            for (int q = 0; q < sifhPkg::PIXEL_NUM; q++) begin
                if (ps == 0) begin
                    ch = maxB[q] << (sifhPkg::NP - sifhPkg::NB);
                    if (ch <= sifhPkg::HALF_WIN)
                        wl[q] = 0;
                    else if (ch > 4095 - sifhPkg::WIN)
                        wl[q] = 4096 - sifhPkg::WIN;
                    else
                        wl[q] = ch - sifhPkg::HALF_WIN;
                end else begin
                    expRes[q] = wl[q] + maxB[q];
                end
            end
        end
    endtask

    task automatic checkEq(input string what, input int got, input int exp);
        checkCount++;
        assert (got == exp) else begin
            errCount++;
            $display("error t=%0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // ************************************************************************
    // Frame driver, two passes each followed by the drain
    // ************************************************************************
    task automatic runFrame(input bit junk);
        modelFrame();
        for (int ps = 0; ps < 2; ps++) begin
            for (int i = 0; i < PASS_SAMPLES; i++) begin
                @(posedge clk);
                wrEn <= 1'b1;
                data <= stim[ps * PASS_SAMPLES + i];
            end
            for (int g = 0; g < 2; g++) begin
                @(posedge clk);
                wrEn <= junk;                         // Strobes into busy
                data <= junk ? sifhPkg::sampleT'(randBits(sifhPkg::NP)) : '0;
                @(negedge clk);
                checkEq("busy in drain", int'(busy), 1);
            end
            @(posedge clk);
            wrEn <= 1'b0;
            @(negedge clk);
            checkEq("busy after drain", int'(busy), 0);
            checkEq("resultValid 3 cycles after last", int'(resultValid), ps);
            checkEq("pass after drain", int'(pass), (ps == 0) ? 1 : 0);
            if (ps == 1) begin
                for (int p = 0; p < sifhPkg::PIXEL_NUM; p++)
                    checkEq($sformatf("result[%0d]", p), int'(result[p]), expRes[p]);
            end
        end
    endtask

    // ************************************************************************
    // Directed tests
    // ************************************************************************
    task automatic cleanPeaks();
        int c [sifhPkg::PIXEL_NUM];
        c = '{'h303, 'h505, 'h902, 'hB06};
        buildPeaked(c, 1'b0);
        runFrame(1'b0);
    endtask

    // Bottom pins to zero, top bin window lies below the cluster
    task automatic clampWindows();
        int c [sifhPkg::PIXEL_NUM];
        c = '{2, 'hFFA, 5, 'hF05};
        buildPeaked(c, 1'b0);
        runFrame(1'b0);
    endtask

    task automatic noiseMix();
        int c [sifhPkg::PIXEL_NUM];
        c = '{'h204, 'h607, 'hA01, 'hD03};
        repeat (2) begin
            buildPeaked(c, 1'b1);
            runFrame(1'b0);
        end
    endtask

    // Pattern A B B A B A C C, B reaches three first
    task automatic tiesFirstWins();
        int base [sifhPkg::PIXEL_NUM];
        int offs [8];
        int i;
        int p;
        base = '{'h400, 'h600, 'h800, 'hA00};
        offs = '{2, 5, 5, 2, 5, 2, 7, 7};
        for (int f = 0; f < 2 * PASS_SAMPLES; f++) begin
            i = f % PASS_SAMPLES;
            p = (i / sifhPkg::DATA_NUM) % sifhPkg::PIXEL_NUM;
            stim[f] = sifhPkg::sampleT'(base[p] + offs[(i / 16) * 4 + i % 4]);
        end
        runFrame(1'b0);
        for (int q = 0; q < sifhPkg::PIXEL_NUM; q++)
            checkEq("tie winner", int'(result[q]), base[q] + 5);
    endtask

    task automatic backPressure();
        int c [sifhPkg::PIXEL_NUM];
        c = '{'h105, 'h704, 'hC03, 'h302};
        buildPeaked(c, 1'b0);
        runFrame(1'b1);
    endtask

    // Leftover counts would skew the later frames
    task automatic backToBack();
        int c [sifhPkg::PIXEL_NUM];
        for (int n = 0; n < 3; n++) begin
            c = '{'h100 + n * 'h300, 'h400 + n * 'h201, 'h900 - n * 'h1FF, 'hE03 - n * 'h500};
            buildPeaked(c, 1'b1);
            runFrame(1'b0);
        end
    endtask

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        wrEn = 1'b0;
        data = '0;
        @(posedge combin_res);
        @(negedge clk);
        checkEq("busy out of reset", int'(busy), 0);
        checkEq("pass out of reset", int'(pass), 0);
        cleanPeaks();
        clampWindows();
        noiseMix();
        tiesFirstWins();
        backPressure();
        backToBack();
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- tests/sifhTop_properties.sv
// Peak finder port properties
// Strobe width, result pass, drain length and reset values on the top level
module sifhTopProperties (
    input logic          clk,
    input logic          combin_res,
    input logic          busy,
    input sifhPkg::passT pass,
    input logic          resultValid
);

    // Result strobe is one cycle wide
    resultPulse : assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |=> !resultValid)
        else $error("resultValid held longer than one cycle");

    // Results only where a fine pass drains back to coarse
    resultAfterFine : assert property (@(posedge clk) disable iff (!combin_res)
        resultValid |-> $fell(busy) && (pass == sifhPkg::COARSE)
                        && ($past(pass) == sifhPkg::FINE))
        else $error("resultValid outside the end of a fine pass");

    // Drain is exactly two cycles
    busyTwoCycles : assert property (@(posedge clk) disable iff (!combin_res)
        $rose(busy) |=> busy ##1 !busy)
        else $error("busy did not last exactly two cycles");

    resetQuiet : assert property (@(posedge clk)
        $rose(combin_res) |-> !busy && !resultValid)
        else $error("busy or resultValid high out of reset");

endmodule

bind sifhTop sifhTopProperties uProps (
    .clk         (clk),
    .combin_res  (combin_res),
    .busy        (busy),
    .pass        (pass),
    .resultValid (resultValid)
);
